// ==== agnus_top.sv ====
// chip-bus core top level, ties the clock block, slot arbiter, chip ram, cpu port and bitplane dma
`timescale 1ns/1ns
`default_nettype none

module agnus_top (
  input  wire                                clk_28,
  input  wire                                locked,
  // cpu pins
  input  wire                                cpu_as,
  input  wire                                cpu_rw,
  input  wire  [amiga_pkg::chip_addr_w-1:0]  cpu_addr,
  input  wire  [amiga_pkg::chip_data_w-1:0]  cpu_wdata,
  output wire                                cpu_dtack,
  output wire  [amiga_pkg::chip_data_w-1:0]  cpu_rdata,
  // bitplane line control and pixel stream
  input  wire                                line_start,
  input  wire  [amiga_pkg::chip_addr_w-1:0]  line_base,
  input  wire  [amiga_pkg::bpl_len_w-1:0]    line_len,
  output wire  [amiga_pkg::chip_data_w-1:0]  pix_data,
  output wire                                pix_valid,
  output wire                                line_done,
  // clock enables
  output wire                                clk7_en,
  output wire                                clk7n_en,
  output wire                                c1,
  output wire                                c3,
  output wire                                cck,
  output wire  [9:0]                         eclk
);

  wire                              ram_we;
  wire [amiga_pkg::chip_addr_w-1:0] ram_addr;
  wire [amiga_pkg::chip_data_w-1:0] ram_wdata;
  wire [amiga_pkg::chip_data_w-1:0] ram_rdata;

  chip_bus_if cpu_bus ();  // cpu port to arbiter
  chip_bus_if dma_bus ();  // bitplane dma to arbiter

  amiga_clk u_clk (
    .clk_28(clk_28), .locked(locked), .clk7_en(clk7_en), .clk7n_en(clk7n_en),
    .c1(c1), .c3(c3), .cck(cck), .eclk(eclk)
  );

  chip_arbiter u_arb (
    .clk_28(clk_28), .locked(locked), .cck(cck), .cpu(cpu_bus.arbiter), .dma(dma_bus.arbiter),
    .ram_we(ram_we), .ram_addr(ram_addr), .ram_wdata(ram_wdata), .ram_rdata(ram_rdata)
  );

  chip_ram u_ram (
    .clk_28(clk_28), .we(ram_we), .addr(ram_addr), .wdata(ram_wdata), .rdata(ram_rdata)
  );

  cpu_bus_port u_cpu (
    .clk_28(clk_28), .locked(locked), .cpu_as(cpu_as), .cpu_rw(cpu_rw), .cpu_addr(cpu_addr),
    .cpu_wdata(cpu_wdata), .bus(cpu_bus.requester), .cpu_dtack(cpu_dtack), .cpu_rdata(cpu_rdata)
  );

  bpl_dma u_bpl (
    .clk_28(clk_28), .locked(locked), .line_start(line_start), .line_base(line_base),
    .line_len(line_len), .bus(dma_bus.requester), .pix_data(pix_data), .pix_valid(pix_valid),
    .line_done(line_done)
  );

endmodule

`default_nettype wire

// ==== all.f ====
amiga_pkg.sv
chip_bus_if.sv
amiga_clk.sv
chip_ram.sv
chip_arbiter.sv
bpl_dma.sv
cpu_bus_port.sv
agnus_top.sv
tb_clk_gen.sv
tb_agnus.sv

// ==== amiga_clk.sv ====
// clock enable generator, divides clk_28 into the 7 MHz enables, c1/c3, cck and the eclk ring
`timescale 1ns/1ns
`default_nettype none

module amiga_clk (
  input  wire        clk_28,
  input  wire        locked,    // async active-low reset
  output logic       clk7_en,   // 7 MHz posedge enable
  output logic       clk7n_en,  // 7 MHz negedge enable
  output logic       c1,
  output logic       c3,
  output logic       cck,       // colour clock, 8 clk_28 cycles per period
  output logic [9:0] eclk       // one-hot, moves every 4 cycles
);

  logic [1:0] clk7_cnt;  // free-running phase counter
  logic       clk_7;

  assign clk_7 = clk7_cnt[1];  // msb gives the 7 MHz level

  always_ff @(posedge clk_28 or negedge locked) begin
    if (!locked) begin
      clk7_cnt <= 2'b10;   // start at phase 2
      clk7_en  <= 1'b1;    // enables held high while not locked
      clk7n_en <= 1'b1;
      cck      <= 1'b1;
      eclk     <= 10'd1;
      c3       <= 1'b1;    // matches clk_7 at phase 2
      c1       <= 1'b0;
    end else begin
      clk7_cnt <= clk7_cnt + 2'b01;
      clk7_en  <= (clk7_cnt == 2'b00);
      clk7n_en <= (clk7_cnt == 2'b10);  // half a 7 MHz period later
      c3       <= clk_7;                // quarter phase behind clk_7
      c1       <= ~c3;
      if (clk7_cnt == 2'b01) begin
        cck <= ~cck;
        // rotate up, recover if the ring ever lost its bit
        if (eclk == '0)
          eclk <= 10'd1;
        else
          eclk <= {eclk[8:0], eclk[9]};
      end
    end
  end

endmodule

`default_nettype wire

// ==== amiga_pkg.sv ====
// shared bus widths and state types for the chip-bus core, referenced by scoped name only
`default_nettype none

package amiga_pkg;

  // chip ram geometry
  localparam int chip_addr_w = 12;  // word address, 4096 words
  localparam int chip_data_w = 16;  // one chip word

  // bitplane line length counter
  localparam int bpl_len_w = 8;     // up to 255 words per line

  // who holds the current memory slot
  typedef enum logic [1:0] {
    owner_none = 2'd0,
    owner_cpu  = 2'd1,
    owner_dma  = 2'd2
  } slot_owner_t;

  // bitplane dma engine state
  typedef enum logic {
    bpl_idle  = 1'b0,  // waiting for line_start
    bpl_fetch = 1'b1   // requesting words
  } bpl_state_t;

endpackage

`default_nettype wire

// ==== bpl_dma.sv ====
// bitplane dma engine, reads line_len words from line_base over the chip bus and streams them out
`timescale 1ns/1ns
`default_nettype none

module bpl_dma (
  input  wire                                clk_28,
  input  wire                                locked,
  input  wire                                line_start,  // one-cycle pulse
  input  wire  [amiga_pkg::chip_addr_w-1:0]  line_base,
  input  wire  [amiga_pkg::bpl_len_w-1:0]    line_len,
  chip_bus_if.requester                      bus,
  output logic [amiga_pkg::chip_data_w-1:0]  pix_data,
  output logic                               pix_valid,
  output logic                               line_done
);

  amiga_pkg::bpl_state_t             state;
  logic [amiga_pkg::chip_addr_w-1:0] ptr;       // next word address
  logic [amiga_pkg::bpl_len_w-1:0]   cnt;       // words still to fetch
  logic                              last_word;

  assign last_word = (cnt == amiga_pkg::bpl_len_w'(1));

  // read-only requester
  assign bus.req   = (state == amiga_pkg::bpl_fetch);
  assign bus.we    = 1'b0;
  assign bus.wdata = '0;
  assign bus.addr  = ptr;

  always_ff @(posedge clk_28 or negedge locked) begin
    if (!locked) begin
      state     <= amiga_pkg::bpl_idle;
      cnt       <= '0;
      pix_valid <= 1'b0;
      line_done <= 1'b0;
    end else begin
      pix_valid <= bus.ack;              // word out one cycle after ack
      line_done <= bus.ack & last_word;  // together with the last word
      case (state)
        amiga_pkg::bpl_idle: begin
          if (line_start) begin
            cnt <= line_len;
            if (line_len == '0)
              line_done <= 1'b1;  // empty line ends right away
            else
              state <= amiga_pkg::bpl_fetch;
          end
        end
        amiga_pkg::bpl_fetch: begin  // line_start ignored here
          if (bus.ack) begin
            cnt <= cnt - amiga_pkg::bpl_len_w'(1);
            if (last_word) state <= amiga_pkg::bpl_idle;
          end
        end
        default: state <= amiga_pkg::bpl_idle;
      endcase
    end
  end

  // payload side, pointer and output word
  always_ff @(posedge clk_28) begin
    if (state == amiga_pkg::bpl_idle && line_start)
      ptr <= line_base;
    else if (bus.ack)
      ptr <= ptr + amiga_pkg::chip_addr_w'(1);  // consecutive words
    if (bus.ack)
      pix_data <= bus.rdata;
  end

endmodule

`default_nettype wire

// ==== chip_arbiter.sv ====
// slot arbiter, opens one chip ram slot per cck rise and grants it to cpu or bitplane dma
`timescale 1ns/1ns
`default_nettype none

module chip_arbiter (
  input  wire                                clk_28,
  input  wire                                locked,
  input  wire                                cck,
  chip_bus_if.arbiter                        cpu,
  chip_bus_if.arbiter                        dma,
  output logic                               ram_we,
  output logic [amiga_pkg::chip_addr_w-1:0]  ram_addr,
  output logic [amiga_pkg::chip_data_w-1:0]  ram_wdata,
  input  wire  [amiga_pkg::chip_data_w-1:0]  ram_rdata
);

  logic                              cck_d;      // cck from last cycle
  logic                              slot_go;    // slot cycle flag
  logic                              parity;     // 1 = odd slot, dma first
  amiga_pkg::slot_owner_t            owner_sel;  // chosen in the slot cycle
  amiga_pkg::slot_owner_t            own_q1;     // ram read in flight
  amiga_pkg::slot_owner_t            own_q2;     // ack cycle
  logic [amiga_pkg::chip_data_w-1:0] rdata_q;

  // pick the owner, preferred peer first then the other one
  always_comb begin
    owner_sel = amiga_pkg::owner_none;
    if (slot_go) begin
      if (parity) begin
        if (dma.req)      owner_sel = amiga_pkg::owner_dma;
        else if (cpu.req) owner_sel = amiga_pkg::owner_cpu;
      end else begin
        if (cpu.req)      owner_sel = amiga_pkg::owner_cpu;
        else if (dma.req) owner_sel = amiga_pkg::owner_dma;
      end
    end
  end

  // ram command only lives for the slot cycle
  assign ram_we    = (owner_sel == amiga_pkg::owner_cpu) ? cpu.we :
                     (owner_sel == amiga_pkg::owner_dma) ? dma.we : 1'b0;
  assign ram_addr  = (owner_sel == amiga_pkg::owner_dma) ? dma.addr : cpu.addr;
  assign ram_wdata = (owner_sel == amiga_pkg::owner_dma) ? dma.wdata : cpu.wdata;

  always_ff @(posedge clk_28 or negedge locked) begin
    if (!locked) begin
      cck_d   <= 1'b1;  // cck resets high, no false edge
      slot_go <= 1'b0;
      parity  <= 1'b0;
      own_q1  <= amiga_pkg::owner_none;
      own_q2  <= amiga_pkg::owner_none;
    end else begin
      cck_d   <= cck;
      slot_go <= cck & ~cck_d;            // slot starts the cycle after the rise
      if (slot_go) parity <= ~parity;
      own_q1  <= owner_sel;               // follows the ram latency
      own_q2  <= own_q1;
    end
  end

  always_ff @(posedge clk_28) rdata_q <= ram_rdata;  // retime ram output for ack

  // ack and data only toward the slot owner
  assign cpu.ack   = (own_q2 == amiga_pkg::owner_cpu);
  assign dma.ack   = (own_q2 == amiga_pkg::owner_dma);
  assign cpu.rdata = cpu.ack ? rdata_q : '0;
  assign dma.rdata = dma.ack ? rdata_q : '0;

endmodule

`default_nettype wire

// ==== chip_bus_if.sv ====
// one peer's chip ram request bundle, requester holds req until a one-cycle ack
`timescale 1ns/1ns
`default_nettype none

interface chip_bus_if;

  logic                              req;    // level, held until ack
  logic                              we;     // 1 = write
  logic [amiga_pkg::chip_addr_w-1:0] addr;
  logic [amiga_pkg::chip_data_w-1:0] wdata;
  logic                              ack;    // one-cycle pulse from arbiter
  logic [amiga_pkg::chip_data_w-1:0] rdata;  // valid with ack

  modport requester (
    output req,
    output we,
    output addr,
    output wdata,
    input  ack,
    input  rdata
  );

  modport arbiter (
    input  req,
    input  we,
    input  addr,
    input  wdata,
    output ack,
    output rdata
  );

endinterface

`default_nettype wire

// ==== chip_ram.sv ====
// single-port chip ram, 4096 x 16, write on the clock and a registered read one cycle later
`timescale 1ns/1ns
`default_nettype none

module chip_ram (
  input  wire                                clk_28,
  input  wire                                we,
  input  wire  [amiga_pkg::chip_addr_w-1:0]  addr,
  input  wire  [amiga_pkg::chip_data_w-1:0]  wdata,
  output logic [amiga_pkg::chip_data_w-1:0]  rdata
);

  // word array
  logic [amiga_pkg::chip_data_w-1:0] mem [0:(1 << amiga_pkg::chip_addr_w)-1];

  always_ff @(posedge clk_28) begin
    if (we)
      mem[addr] <= wdata;  // write lands at the edge
    rdata <= mem[addr];    // old contents on a same-cycle write
  end

endmodule

`default_nettype wire

// ==== cpu_bus_port.sv ====
// cpu side of the chip bus, latches a strobed access, waits for its slot and answers with dtack
`timescale 1ns/1ns
`default_nettype none

module cpu_bus_port (
  input  wire                                clk_28,
  input  wire                                locked,
  input  wire                                cpu_as,     // one-cycle address strobe
  input  wire                                cpu_rw,     // 1 = read
  input  wire  [amiga_pkg::chip_addr_w-1:0]  cpu_addr,
  input  wire  [amiga_pkg::chip_data_w-1:0]  cpu_wdata,
  chip_bus_if.requester                      bus,
  output logic                               cpu_dtack,  // end of access
  output logic [amiga_pkg::chip_data_w-1:0]  cpu_rdata
);

  logic                              pending;  // access waiting for its slot
  logic                              take;
  logic                              we_q;
  logic [amiga_pkg::chip_addr_w-1:0] addr_q;
  logic [amiga_pkg::chip_data_w-1:0] wdata_q;

  assign take = cpu_as & ~pending;  // strobes while busy are dropped

  // request held stable until ack
  assign bus.req   = pending;
  assign bus.we    = we_q;
  assign bus.addr  = addr_q;
  assign bus.wdata = wdata_q;

  always_ff @(posedge clk_28 or negedge locked) begin
    if (!locked) begin
      pending   <= 1'b0;
      cpu_dtack <= 1'b0;
    end else begin
      cpu_dtack <= bus.ack;  // one cycle after the arbiter ack
      if (bus.ack)
        pending <= 1'b0;
      else if (take)
        pending <= 1'b1;
    end
  end

  // access payload and returned word
  always_ff @(posedge clk_28) begin
    if (take) begin
      we_q    <= ~cpu_rw;
      addr_q  <= cpu_addr;
      wdata_q <= cpu_wdata;
    end
    if (bus.ack)
      cpu_rdata <= bus.rdata;  // don't care on writes
  end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module tb_agnus -f all.f -o tb_agnus_sim
./obj_dir/tb_agnus_sim > sim.log
cat sim.log
if grep -q "^Simulation passed$" sim.log; then
  echo "PASS"
else
  echo "FAIL"
  exit 1
fi

// ==== tb_agnus.sv ====
// testbench top that drives cpu and bitplane traffic into agnus_top and checks it with assertions
`timescale 1ns/1ns
`default_nettype none

module tb_agnus;

  logic clk_28, locked, cpu_as, cpu_rw, cpu_dtack, line_start, pix_valid, line_done;
  logic clk7_en, clk7n_en, c1, c3, cck;
  logic [9:0] eclk, eclk_q, eclk_exp;
  logic [amiga_pkg::chip_addr_w-1:0] cpu_addr, line_base, line_base_q;
  logic [amiga_pkg::chip_data_w-1:0] cpu_wdata, cpu_rdata, pix_data, exp_data, pix_exp;
  logic [amiga_pkg::bpl_len_w-1:0]   line_len, line_cnt, pix_idx;
  logic [amiga_pkg::chip_data_w-1:0] ref_mem [0:(1 << amiga_pkg::chip_addr_w)-1];  // cpu writes
  logic [amiga_pkg::chip_addr_w-1:0] addrs [0:39];   // write addresses that are read back later
  logic [3:0] lock_cnt;
  logic [7:0] cpu_wait;
  logic       clk_ok, cpu_busy, exp_rd, line_active, cck_q;
  logic [31:0] seed, r;
  int         errors = 0;
  int         cycles = 0;
  string      test_name = "reset";

  tb_clk_gen u_clk_gen (.clk_28(clk_28), .locked(locked));
  agnus_top UUT (.*);

  function automatic logic [9:0] rotate_up(input logic [9:0] v);
    rotate_up = {v[8:0], v[9]};  // bit 9 wraps to bit 0
  endfunction

  // count one failed check and print its line
  task automatic report_error(input string msg);
    errors = errors + 1;
    $display("%s", msg);
  endtask

  // cycles since locked so the clock checks see a full history
  always_ff @(posedge clk_28 or negedge locked) begin
    if (!locked) lock_cnt <= 4'd0;
    else if (lock_cnt != 4'd8) lock_cnt <= lock_cnt + 4'd1;
  end
  assign clk_ok = (lock_cnt == 4'd8);

  always_ff @(posedge clk_28) begin
    eclk_q <= eclk;
    cck_q  <= cck;
  end
  assign eclk_exp = (cck != cck_q) ? rotate_up(eclk_q) : eclk_q;  // moves with each cck edge

  // tracks the one outstanding cpu access
  always_ff @(posedge clk_28 or negedge locked) begin
    if (!locked) begin
      cpu_busy <= 1'b0;
      cpu_wait <= 8'd0;
      exp_rd   <= 1'b0;
      exp_data <= '0;
    end else if (cpu_as) begin
      cpu_busy <= 1'b1;
      cpu_wait <= 8'd0;
      exp_rd   <= cpu_rw;
      exp_data <= ref_mem[cpu_addr];   // mirror already holds every earlier write
    end else if (cpu_dtack) cpu_busy <= 1'b0;
    else if (cpu_busy) cpu_wait <= cpu_wait + 8'd1;
  end

  // bitplane line in progress and the word index expected next
  always_ff @(posedge clk_28 or negedge locked) begin
    if (!locked) begin
      line_active <= 1'b0;
      line_base_q <= '0;
      line_cnt    <= '0;
      pix_idx     <= '0;
    end else begin
      if (line_start && !line_active) begin
        line_active <= 1'b1;
        line_base_q <= line_base;
        line_cnt    <= line_len;
        pix_idx     <= '0;
      end else if (line_done) line_active <= 1'b0;
      if (pix_valid) pix_idx <= pix_idx + 8'd1;
    end
  end
  assign pix_exp = ref_mem[line_base_q + amiga_pkg::chip_addr_w'(pix_idx)];

  a_reset: assert property (@(posedge clk_28)
    !locked |-> (!cpu_dtack && !pix_valid && !line_done && clk7_en))
    else report_error("outputs not at reset values while locked is low");
  a_clk7: assert property (@(posedge clk_28) disable iff (!clk_ok)
    clk7_en == (!$past(clk7_en, 1) && !$past(clk7_en, 2) && !$past(clk7_en, 3)))
    else report_error("clk7_en does not pulse every 4 cycles");
  a_clk7n: assert property (@(posedge clk_28) disable iff (!clk_ok) clk7n_en == $past(clk7_en, 2))
    else report_error("clk7n_en is not 2 cycles after clk7_en");
  a_cck: assert property (@(posedge clk_28) disable iff (!clk_ok)
    (cck != $past(cck)) == $past(clk7_en))
    else report_error("cck does not toggle every 4 cycles");
  a_c3: assert property (@(posedge clk_28) disable iff (!clk_ok) c3 == !$past(c3, 2))
    else report_error("c3 is not a square wave with a 4 cycle period");
  a_c1: assert property (@(posedge clk_28) disable iff (!clk_ok) c1 == !$past(c3))
    else report_error("c1 is not c3 inverted one cycle later");
  a_eclk_hot: assert property (@(posedge clk_28) disable iff (!clk_ok) $onehot(eclk))
    else report_error($sformatf("eclk is not one-hot: %b", eclk));
  a_eclk_step: assert property (@(posedge clk_28) disable iff (!clk_ok) eclk == eclk_exp)
    else report_error($sformatf("CHECK FAILED %s: eclk expected %b, actual %b",
                                test_name, eclk_exp, eclk));
  a_dtack_once: assert property (@(posedge clk_28) disable iff (!locked) cpu_dtack |-> cpu_busy)
    else report_error("cpu_dtack with no cpu access pending");
  a_dtack_time: assert property (@(posedge clk_28) disable iff (!locked)
    cpu_busy |-> cpu_wait != 8'd24)
    else report_error("cpu access got no dtack within 24 cycles");
  a_cpu_rdata: assert property (@(posedge clk_28) disable iff (!locked)
    (cpu_dtack && exp_rd) |-> cpu_rdata == exp_data)
    else report_error($sformatf("CHECK FAILED %s: cpu_rdata expected %h, actual %h",
                                test_name, exp_data, cpu_rdata));
  a_pix_extra: assert property (@(posedge clk_28) disable iff (!locked)
    pix_valid |-> (line_active && pix_idx < line_cnt))
    else report_error("pix_valid outside a line or past its length");
  a_pix_data: assert property (@(posedge clk_28) disable iff (!locked)
    pix_valid |-> pix_data == pix_exp)
    else report_error($sformatf("CHECK FAILED %s: pix_data expected %h, actual %h",
                                test_name, pix_exp, pix_data));
  a_line_done: assert property (@(posedge clk_28) disable iff (!locked)
    line_done == (line_active && (line_cnt == '0 || (pix_valid && pix_idx == line_cnt - 8'd1))))
    else report_error("line_done not with the last word of the line");

  // one strobed access that returns once dtack has been seen
  task automatic cpu_access(input logic rd, input logic [11:0] a, input logic [15:0] d);
    cpu_rw    = rd;
    cpu_addr  = a;
    cpu_wdata = d;
    cpu_as    = 1'b1;
    if (!rd) ref_mem[a] = d;
    @(posedge clk_28);
    #1 cpu_as = 1'b0;
    while (!cpu_dtack) begin
      @(posedge clk_28);
      #1;
    end
  endtask

  task automatic start_line(input logic [11:0] base, input logic [7:0] len);
    line_base  = base;
    line_len   = len;
    line_start = 1'b1;
    @(posedge clk_28);
    #1 line_start = 1'b0;
  endtask

  task automatic wait_line_end;
    while (line_active) begin
      @(posedge clk_28);
      #1;
    end
  endtask

  // run limit covers ~90 accesses at 24 cycles plus three lines of 16 slots with margin
  always @(posedge clk_28) begin
    cycles = cycles + 1;
    if (cycles == 4000) begin
      $display("timeout after %0d cycles, DUT stopped answering", cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  initial begin
    seed = 32'h31ff;
    cpu_as = 1'b0;
    cpu_rw = 1'b1;
    cpu_addr = '0;
    cpu_wdata = '0;
    line_start = 1'b0;
    line_base = '0;
    line_len = '0;
    wait (lock_cnt == 4'd8);
    @(posedge clk_28);
    #1 test_name = "cpu_write";
    for (int i = 0; i < 40; i++) begin
      r = $random(seed);
      addrs[i] = (i < 16) ? 12'h3c0 + 12'(i) : r[27:16];  // first 16 cover the line area
      cpu_access(1'b0, addrs[i], r[15:0]);
    end
    test_name = "cpu_read";
    for (int i = 0; i < 40; i++) cpu_access(1'b1, addrs[i], 16'h0000);
    test_name = "bpl_line";
    start_line(12'h3c0, 8'd16);
    wait_line_end();
    test_name = "bpl_share";                 // cpu reads race the fetch for slots
    start_line(12'h3c0, 8'd16);
    for (int i = 0; i < 8; i++) cpu_access(1'b1, addrs[i * 5], 16'h0000);
    wait_line_end();
    test_name = "bpl_empty";
    start_line(12'h3c0, 8'd0);
    wait_line_end();
    repeat (4) @(posedge clk_28);
    $display("run complete, %0d errors", errors);
    if (errors == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb_clk_gen.sv ====
// testbench clock and reset source, clk_28 at a 4 ns period and locked held low for 10 cycles
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen (
  output logic clk_28,
  output logic locked
);

  initial begin
    clk_28 = 1'b0;
    locked = 1'b1;              // starts high so the drop below is a real negedge
    #1 locked = 1'b0;           // async reset in
    repeat (10) @(posedge clk_28);
    #1 locked = 1'b1;           // released just after an edge
  end

  always #2 clk_28 = ~clk_28;   // first rise at 2 ns

endmodule

`default_nettype wire
